//--- dv/trace_cases.txt
# name grp ctl pc instr half irqno exrd exdata mk maddr mdata wbrd wbdata, then expected
# instr irq irqno rd rdata mk maddr mdata; hex, ctl 1 ser 2 hold 4 drop 8 ill 10 c 20 irq
alu_add 1 1 80 00a50533 0 0 a 15 0 0 0 0 0 00a50533 0 0 a 15 0 0 0
c_mv 2 11 84 0 4505 0 a 7 0 0 0 0 0 45054505 0 0 a 7 0 0 0
irq_alu 2 21 100 00b00593 0 7 b b 0 0 0 0 0 00b00593 1 7 b b 0 0 0
st_word 3 1 104 00b52023 0 0 0 0 2 200 cafe 0 0 00b52023 0 0 0 0 2 200 cafe
ld_word 3 1 108 00052303 0 0 0 0 1 204 beef 6 beef 00052303 0 0 6 beef 1 204 beef
ovl_a 4 0 10c 00100093 0 0 1 1 0 0 0 0 0 00100093 0 0 1 1 0 0 0
ovl_ill 4 8 110 ffffffff 0 0 0 0 0 0 0 0 0 ffffffff 0 0 0 0 0 0 0
ovl_c 4 0 114 00200113 0 0 2 2 0 0 0 2 22 00200113 0 0 2 22 0 0 0
cr_0 5 3 118 00300193 0 0 3 30 0 0 0 0 0 00300193 0 0 3 30 0 0 0
cr_1 5 3 11c 00400193 0 0 3 31 0 0 0 0 0 00400193 0 0 3 31 0 0 0
cr_2 5 3 120 00500193 0 0 3 32 0 0 0 0 0 00500193 0 0 3 32 0 0 0
cr_3 5 3 124 00600193 0 0 3 33 0 0 0 0 0 00600193 0 0 3 33 0 0 0
cr_4 5 3 128 00700193 0 0 3 34 0 0 0 0 0 00700193 0 0 3 34 0 0 0
cr_5 5 3 12c 00800193 0 0 3 35 0 0 0 0 0 00800193 0 0 3 35 0 0 0
lost_0 6 2 130 00100213 0 0 4 40 0 0 0 0 0 00100213 0 0 4 40 0 0 0
lost_1 6 2 134 00200213 0 0 4 41 0 0 0 0 0 00200213 0 0 4 41 0 0 0
lost_2 6 2 138 00300213 0 0 4 42 0 0 0 0 0 00300213 0 0 4 42 0 0 0
lost_3 6 2 13c 00400213 0 0 4 43 0 0 0 0 0 00400213 0 0 4 43 0 0 0
lost_4 6 6 140 00500213 0 0 4 44 0 0 0 0 0 0 0 0 0 0 0 0 0

//--- src.f
hdl/trace_pkg.sv
hdl/trace_fifo.sv
hdl/trace_cycle_counter.sv
hdl/trace_id_capture.sv
hdl/trace_ex_collect.sv
hdl/trace_wb_merge.sv
hdl/trace_emit_fsm.sv
hdl/trace_unit.sv
dv/tb_trace_unit.sv

//--- Bender.yml
package:
  name: trace_unit

sources:
  - hdl/trace_pkg.sv
  - hdl/trace_fifo.sv
  - hdl/trace_cycle_counter.sv
  - hdl/trace_id_capture.sv
  - hdl/trace_ex_collect.sv
  - hdl/trace_wb_merge.sv
  - hdl/trace_emit_fsm.sv
  - hdl/trace_unit.sv
  - target: test
    files:
      - dv/tb_trace_unit.sv

//--- dv/tb_trace_unit.sv
////////////////////
// drives trace_unit from the cases in dv/trace_cases.txt
// lines of one group run together and start with all credits back
// cycle stamps are predicted from a local edge count
////////////////////
module tb_trace_unit
  import trace_pkg::*;
();

  localparam int MAXN = 32;
  localparam int TMO  = 400;
  // case columns
  localparam int F_GRP   = 0;
  localparam int F_CTL   = 1;
  localparam int F_PC    = 2;
  localparam int F_INSTR = 3;
  localparam int F_HALF  = 4;
  localparam int F_IRQN  = 5;
  localparam int F_EXRD  = 6;
  localparam int F_EXD   = 7;
  localparam int F_MK    = 8;
  localparam int F_MA    = 9;
  localparam int F_MD    = 10;
  localparam int F_WBRD  = 11;
  localparam int F_WBD   = 12;
  localparam int X_INSTR = 13;
  localparam int X_IRQ   = 14;
  localparam int X_IRQN  = 15;
  localparam int X_RD    = 16;
  localparam int X_RDATA = 17;
  localparam int X_MK    = 18;
  localparam int X_MA    = 19;
  localparam int X_MD    = 20;
  // ctl bits
  localparam int B_SER  = 0;
  localparam int B_HOLD = 1;
  localparam int B_DROP = 2;
  localparam int B_ILL  = 3;
  localparam int B_COMP = 4;
  localparam int B_IRQ  = 5;

  logic       clk;
  logic       rst_n;
  logic       if_valid;
  logic       pc_set;
  logic       is_interrupt;
  irq_no_t    irq_no;
  half_t      instr_compressed;
  id_event_t  id_event;
  logic       id_fire;
  ex_event_t  ex_event;
  logic       ex_done;
  wb_event_t  wb_event;
  logic       wb_data_rvalid;
  word_t      wb_data_rdata;
  logic       credit_return;
  logic       trace_valid;
  trace_rec_t trace_rec;
  logic       trace_lost;

  string       c_name [MAXN];
  logic [31:0] fld [MAXN][21];
  cycle_t      e_cycle [MAXN];
  int          n_cases;
  trace_rec_t  seen_q [$];
  int          outstanding = 0;
  int          credit_wait = 0;
  logic        hold = 1'b0;
  integer      seed = 32'h95c3fab4;
  int          edge_cnt = 0;
  int          errors = 0;
  int          tests_ok = 0;
  int          tests_bad = 0;
  logic        exp_lost = 1'b0;
  bit          abort_req = 1'b0;

  trace_unit u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // edges since reset release give the DUT stamp of the next capture
  always @(posedge clk) begin
    if (rst_n) begin
      edge_cnt <= edge_cnt + 1;
    end
  end

  // sink model takes every valid record at once
  always @(posedge clk) begin
    if (rst_n && trace_valid) begin
      seen_q.push_back(trace_rec);
      outstanding = outstanding + 1;
    end
  end

  // credits go back after a random pause unless held
  initial begin
    credit_return = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      credit_return = 1'b0;
      if (credit_wait > 0) begin
        credit_wait = credit_wait - 1;
      end else if (rst_n && !hold && outstanding > 0) begin
        credit_return = 1'b1;
        outstanding   = outstanding - 1;
        credit_wait   = $unsigned($random(seed)) % 4;
      end
    end
  end

  initial begin
    wait (abort_req);
    $display("STATUS: FAIL");
    $finish;
  end

  task automatic abort_run(input string why);
    $display("run stopped: %s", why);
    abort_req = 1'b1;
    forever @(posedge clk);
  endtask

  task automatic compare(input string tname, input string what,
                         input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s %s: expected %h, actual %h", tname, what, exp, act);
      errors = errors + 1;
    end
  endtask

  // one cycle on with all pulses back to idle
  task automatic next_cycle();
    @(posedge clk);
    #2;
    if_valid       = 1'b0;
    pc_set         = 1'b0;
    is_interrupt   = 1'b0;
    id_fire        = 1'b0;
    ex_done        = 1'b0;
    ex_event       = '0;
    wb_event       = '0;
    wb_data_rvalid = 1'b0;
  endtask

  task automatic load_cases();
    int    fd;
    int    n;
    string line;
    fd = $fopen("dv/trace_cases.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open dv/trace_cases.txt");
    end
    n_cases = 0;
    while (!$feof(fd) && n_cases < MAXN) begin
      n = $fgets(line, fd);
      if (n > 1 && line[0] != "#") begin
        n = $sscanf(line,
          "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
          c_name[n_cases], fld[n_cases][0], fld[n_cases][1], fld[n_cases][2],
          fld[n_cases][3], fld[n_cases][4], fld[n_cases][5], fld[n_cases][6],
          fld[n_cases][7], fld[n_cases][8], fld[n_cases][9], fld[n_cases][10],
          fld[n_cases][11], fld[n_cases][12], fld[n_cases][13], fld[n_cases][14],
          fld[n_cases][15], fld[n_cases][16], fld[n_cases][17], fld[n_cases][18],
          fld[n_cases][19], fld[n_cases][20]);
        if (n == 22) begin
          n_cases = n_cases + 1;
        end
      end
    end
    $fclose(fd);
  endtask

  // IF fetch, optional interrupt entry, then the decode pulse
  task automatic decode(input int i);
    if (fld[i][F_CTL][B_IRQ]) begin
      next_cycle();
      pc_set       = 1'b1;
      is_interrupt = 1'b1;
      irq_no       = fld[i][F_IRQN][4:0];
    end
    next_cycle();
    if_valid         = 1'b1;
    instr_compressed = fld[i][F_HALF][15:0];
    next_cycle();
    id_fire                = 1'b1;
    id_event.pc            = fld[i][F_PC];
    id_event.instr         = fld[i][F_INSTR];
    id_event.is_compressed = fld[i][F_CTL][B_COMP];
    id_event.is_illegal    = fld[i][F_CTL][B_ILL];
    e_cycle[i] = cycle_t'(edge_cnt);
    if (fld[i][F_CTL][B_DROP]) begin
      exp_lost = 1'b1;
    end
  endtask

  task automatic execute(input int i);
    next_cycle();
    ex_done            = 1'b1;
    ex_event.reg_we    = (fld[i][F_EXRD] != 0);
    ex_event.reg_addr  = fld[i][F_EXRD][4:0];
    ex_event.reg_wdata = fld[i][F_EXD];
    if (fld[i][F_MK] != 0) begin
      ex_event.data_req   = 1'b1;
      ex_event.data_gnt   = 1'b1;
      ex_event.data_we    = (fld[i][F_MK] == 2);
      ex_event.data_addr  = fld[i][F_MA];
      ex_event.data_wdata = (fld[i][F_MK] == 2) ? fld[i][F_MD] : '0;
    end
    next_cycle();
  endtask

  // load data goes ahead of wb_valid
  task automatic writeback(input int i);
    if (fld[i][F_MK] == 1) begin
      next_cycle();
      wb_data_rvalid = 1'b1;
      wb_data_rdata  = fld[i][F_MD];
    end
    next_cycle();
    wb_event.wb_valid  = 1'b1;
    wb_event.reg_we    = (fld[i][F_WBRD] != 0);
    wb_event.reg_addr  = fld[i][F_WBRD][4:0];
    wb_event.reg_wdata = fld[i][F_WBD];
    next_cycle();
    next_cycle();
  endtask

  task automatic check_record(input int i, input trace_rec_t r);
    int e0;
    e0 = errors;
    compare(c_name[i], "pc", fld[i][F_PC], r.pc);
    compare(c_name[i], "instr", fld[i][X_INSTR], r.instr);
    compare(c_name[i], "cycle", e_cycle[i], r.cycle);
    compare(c_name[i], "irq", fld[i][X_IRQ], 32'(r.irq));
    if (fld[i][X_IRQ] != 0) begin
      compare(c_name[i], "irq_no", fld[i][X_IRQN], 32'(r.irq_no));
    end
    compare(c_name[i], "illegal", 32'(fld[i][F_CTL][B_ILL]), 32'(r.illegal));
    compare(c_name[i], "reg valid", 32'(fld[i][X_RD] != 0), 32'(r.reg_wr.valid));
    if (fld[i][X_RD] != 0) begin
      compare(c_name[i], "reg addr", fld[i][X_RD], 32'(r.reg_wr.addr));
      compare(c_name[i], "reg data", fld[i][X_RDATA], r.reg_wr.data);
    end
    compare(c_name[i], "mem valid", 32'(fld[i][X_MK] != 0), 32'(r.mem.valid));
    if (fld[i][X_MK] != 0) begin
      compare(c_name[i], "mem we", 32'(fld[i][X_MK] == 2), 32'(r.mem.we));
      compare(c_name[i], "mem addr", fld[i][X_MA], r.mem.addr);
      compare(c_name[i], "mem data", fld[i][X_MD], r.mem.data);
    end
    if (errors == e0) begin
      $display("test %s: ok", c_name[i]);
      tests_ok = tests_ok + 1;
    end else begin
      $display("test %s: failed", c_name[i]);
      tests_bad = tests_bad + 1;
    end
  endtask

  task automatic run_group(input int first, input int last);
    int  n;
    int  k;
    int  nexp;
    int  e0;
    bit  ser;
    n = 0;
    while (outstanding != 0 && n < TMO) begin
      next_cycle();
      n = n + 1;
    end
    if (outstanding != 0) begin
      abort_run("credits were not returned by the sink model");
    end
    repeat (3) next_cycle();
    seen_q.delete();
    hold = fld[first][F_CTL][B_HOLD];
    ser  = fld[first][F_CTL][B_SER];
    nexp = 0;
    for (int i = first; i <= last; i++) begin
      if (!fld[i][F_CTL][B_DROP]) begin
        nexp = nexp + 1;
      end
    end
    ////////////////////
    // drive the group
    ////////////////////
    if (ser) begin
      for (int i = first; i <= last; i++) begin
        decode(i);
        if (!fld[i][F_CTL][B_ILL] && !fld[i][F_CTL][B_DROP]) begin
          execute(i);
          writeback(i);
        end
      end
    end else begin
      for (int i = first; i <= last; i++) begin
        decode(i);
      end
      for (int i = first; i <= last; i++) begin
        if (!fld[i][F_CTL][B_ILL] && !fld[i][F_CTL][B_DROP]) begin
          execute(i);
        end
      end
      for (int i = first; i <= last; i++) begin
        if (!fld[i][F_CTL][B_ILL] && !fld[i][F_CTL][B_DROP]) begin
          writeback(i);
        end
      end
    end
    // with credits withheld only the reset credits may be spent
    if (hold) begin
      repeat (30) next_cycle();
      k = (nexp < TRACE_CREDITS) ? nexp : TRACE_CREDITS;
      compare(c_name[first], "records under held credits", k, seen_q.size());
      hold = 1'b0;
    end
    n = 0;
    while (seen_q.size() < nexp && n < TMO) begin
      next_cycle();
      n = n + 1;
    end
    repeat (10) next_cycle();
    if (seen_q.size() != nexp) begin
      $display("group of %s gave %0d records where %0d were due",
               c_name[first], seen_q.size(), nexp);
      errors = errors + 1;
    end
    ////////////////////
    // match in program order
    ////////////////////
    k = 0;
    for (int i = first; i <= last; i++) begin
      if (fld[i][F_CTL][B_DROP]) begin
        // a dropped record leaves only the lost flag behind
        e0 = errors;
        compare(c_name[i], "trace_lost", 32'd1, 32'(trace_lost));
        if (errors == e0 && seen_q.size() == nexp) begin
          $display("test %s: dropped, not in trace", c_name[i]);
          tests_ok = tests_ok + 1;
        end else begin
          $display("test %s: failed", c_name[i]);
          tests_bad = tests_bad + 1;
        end
      end else if (k < seen_q.size()) begin
        check_record(i, seen_q[k]);
        k = k + 1;
      end else begin
        $display("test %s: record never came out", c_name[i]);
        errors    = errors + 1;
        tests_bad = tests_bad + 1;
      end
    end
    compare(c_name[last], "trace_lost", 32'(exp_lost), 32'(trace_lost));
  endtask

  initial begin
    int i;
    int j;
    rst_n            = 1'b0;
    if_valid         = 1'b0;
    pc_set           = 1'b0;
    is_interrupt     = 1'b0;
    irq_no           = '0;
    instr_compressed = '0;
    id_event         = '0;
    id_fire          = 1'b0;
    ex_event         = '0;
    ex_done          = 1'b0;
    wb_event         = '0;
    wb_data_rvalid   = 1'b0;
    wb_data_rdata    = '0;
    load_cases();
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    i = 0;
    while (i < n_cases) begin
      j = i;
      while (j + 1 < n_cases && fld[j + 1][F_GRP] == fld[i][F_GRP]) begin
        j = j + 1;
      end
      run_group(i, j);
      i = j + 1;
    end
    $display("tests ok %0d, failed %0d, errors %0d", tests_ok, tests_bad, errors);
    if (errors == 0 && tests_bad == 0 && n_cases > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- hdl/trace_unit.sv
////////////////////
// retirement trace unit, never stalls the core
// trace_valid needs a credit, trace_lost flags a dropped record
// rdata with a full rd queue is an error
////////////////////
module trace_unit
  import trace_pkg::*;
#(
  parameter int TRACE_DEPTH   = trace_pkg::TRACE_DEPTH,
  parameter int TRACE_CREDITS = trace_pkg::TRACE_CREDITS
) (
  input  logic       clk,
  input  logic       rst_n,
  // IF side
  input  logic       if_valid,
  input  logic       pc_set,
  input  logic       is_interrupt,
  input  irq_no_t    irq_no,
  input  half_t      instr_compressed,
  // decode, execute and write-back
  input  id_event_t  id_event,
  input  logic       id_fire,
  input  ex_event_t  ex_event,
  input  logic       ex_done,
  input  wb_event_t  wb_event,
  input  logic       wb_data_rvalid,
  input  word_t      wb_data_rdata,
  // sink
  input  logic       credit_return,
  output logic       trace_valid,
  output trace_rec_t trace_rec,
  output logic       trace_lost
);

  cycle_t     cycle;

  // ID to EX queue
  logic       ex_q_push;
  logic       ex_q_pop;
  logic       ex_q_full;
  logic       ex_q_empty;
  trace_rec_t ex_q_din;
  trace_rec_t ex_q_dout;

  // EX to WB queue
  logic       wb_q_push;
  logic       wb_q_pop;
  logic       wb_q_full;
  logic       wb_q_empty;
  trace_rec_t wb_q_din;
  trace_rec_t wb_q_dout;

  // load data
  logic       rd_q_pop;
  logic       rd_q_full;
  logic       rd_q_empty;
  word_t      rd_q_dout;

  // finished records
  logic       out_q_push;
  logic       out_q_pop;
  logic       out_q_full;
  logic       out_q_empty;
  trace_rec_t out_q_din;
  trace_rec_t out_q_dout;

  trace_cycle_counter u_cnt (
    .clk   (clk),
    .rst_n (rst_n),
    .cycle (cycle)
  );

  trace_id_capture u_id (
    .clk              (clk),
    .rst_n            (rst_n),
    .if_valid         (if_valid),
    .pc_set           (pc_set),
    .is_interrupt     (is_interrupt),
    .irq_no           (irq_no),
    .instr_compressed (instr_compressed),
    .id_fire          (id_fire),
    .id_event         (id_event),
    .cycle            (cycle),
    .q_full           (ex_q_full),
    .push             (ex_q_push),
    .rec              (ex_q_din),
    .lost             (trace_lost)
  );

  trace_fifo #(.DEPTH(TRACE_DEPTH), .T(trace_rec_t)) u_ex_q (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (ex_q_push),
    .din   (ex_q_din),
    .pop   (ex_q_pop),
    .dout  (ex_q_dout),
    .full  (ex_q_full),
    .empty (ex_q_empty)
  );

  trace_ex_collect u_ex (
    .clk        (clk),
    .rst_n      (rst_n),
    .head       (ex_q_dout),
    .head_empty (ex_q_empty),
    .ex_done    (ex_done),
    .ex_event   (ex_event),
    .out_full   (wb_q_full),
    .pop        (ex_q_pop),
    .push       (wb_q_push),
    .rec        (wb_q_din)
  );

  trace_fifo #(.DEPTH(TRACE_DEPTH), .T(trace_rec_t)) u_wb_q (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (wb_q_push),
    .din   (wb_q_din),
    .pop   (wb_q_pop),
    .dout  (wb_q_dout),
    .full  (wb_q_full),
    .empty (wb_q_empty)
  );

  trace_fifo #(.DEPTH(TRACE_DEPTH), .T(word_t)) u_rd_q (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (wb_data_rvalid),
    .din   (wb_data_rdata),
    .pop   (rd_q_pop),
    .dout  (rd_q_dout),
    .full  (rd_q_full),
    .empty (rd_q_empty)
  );

  trace_wb_merge u_wb (
    .clk        (clk),
    .rst_n      (rst_n),
    .head       (wb_q_dout),
    .head_empty (wb_q_empty),
    .wb_event   (wb_event),
    .rd_data    (rd_q_dout),
    .rd_empty   (rd_q_empty),
    .wb_pop     (wb_q_pop),
    .rd_pop     (rd_q_pop),
    .push       (out_q_push),
    .rec        (out_q_din),
    .out_full   (out_q_full)
  );

  trace_fifo #(.DEPTH(TRACE_DEPTH), .T(trace_rec_t)) u_out_q (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (out_q_push),
    .din   (out_q_din),
    .pop   (out_q_pop),
    .dout  (out_q_dout),
    .full  (out_q_full),
    .empty (out_q_empty)
  );

  trace_emit_fsm #(.CREDITS(TRACE_CREDITS)) u_emit (
    .clk           (clk),
    .rst_n         (rst_n),
    .head          (out_q_dout),
    .head_empty    (out_q_empty),
    .credit_return (credit_return),
    .pop           (out_q_pop),
    .trace_valid   (trace_valid),
    .trace_rec     (trace_rec)
  );

  // rdata has nowhere to wait, the rd queue must have room
  a_rd_room: assert property (@(posedge clk) disable iff (!rst_n)
    wb_data_rvalid |-> (!rd_q_full || rd_q_pop))
    else $error("load data arrived with the rd queue full");

endmodule

//--- hdl/trace_emit_fsm.sv
////////////////////
// sends finished records to the sink, one credit per record
// the sink takes every valid record in the same cycle
////////////////////
module trace_emit_fsm
  import trace_pkg::*;
#(
  parameter int CREDITS = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  trace_rec_t head,
  input  logic       head_empty,
  input  logic       credit_return,
  output logic       pop,
  output logic       trace_valid,
  output trace_rec_t trace_rec
);

  typedef enum logic [1:0] {
    IDLE,
    SEND,
    STARVED
  } state_e;

  state_e  state;
  state_e  state_d;
  credit_t credits;
  credit_t avail;
  logic    can_send;

  // record in flight this cycle still holds its credit
  assign avail    = credits - credit_t'(trace_valid);
  assign can_send = !head_empty && (avail != '0);
  assign pop      = can_send;

  ////////////////////
  // next state
  ////////////////////
  always_comb begin
    if (can_send) begin
      state_d = SEND;
    end else if (!head_empty) begin
      // records waiting, no credit left
      state_d = STARVED;
    end else begin
      state_d = IDLE;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      credits <= credit_t'(CREDITS);
    end else begin
      state <= state_d;
      // spend on the valid cycle, refill on each return pulse
      credits <= credits - credit_t'(trace_valid) + credit_t'(credit_return);
    end
  end

  // record register, loaded with the head on each pop
  always_ff @(posedge clk) begin
    if (can_send) begin
      trace_rec <= head;
    end
  end

  assign trace_valid = (state == SEND);

  // sink must never return more credits than it was given
  a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
    credits <= credit_t'(CREDITS))
    else $error("credit count above %0d", CREDITS);

endmodule

//--- hdl/trace_wb_merge.sv
////////////////////
// completes records with the WB register write and load data
// loads wait for rdata in the rd queue, stores take none
// illegal records pass through untouched
////////////////////
module trace_wb_merge
  import trace_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  trace_rec_t head,
  input  logic       head_empty,
  input  wb_event_t  wb_event,
  input  word_t      rd_data,
  input  logic       rd_empty,
  output logic       wb_pop,
  output logic       rd_pop,
  output logic       push,
  output trace_rec_t rec,
  input  logic       out_full
);

  // wb_valid seen while the record still waits on load data or room
  logic    wb_seen_q;
  reg_wr_t wb_reg_q;

  reg_wr_t wb_reg;
  logic    wb_done;
  logic    needs_load;
  logic    ready;
  logic    move;

  // register write reported by WB this cycle, or the one held
  always_comb begin
    wb_reg = '0;
    if (wb_seen_q) begin
      wb_reg = wb_reg_q;
    end else if (wb_event.wb_valid && wb_event.reg_we) begin
      wb_reg.valid = 1'b1;
      wb_reg.addr  = wb_event.reg_addr;
      wb_reg.data  = wb_event.reg_wdata;
    end
  end

  assign wb_done    = wb_event.wb_valid || wb_seen_q;
  assign needs_load = head.mem.valid && !head.mem.we;
  assign ready      = head.illegal || (wb_done && (!needs_load || !rd_empty));
  assign move       = !head_empty && !out_full && ready;

  assign wb_pop = move;
  assign push   = move;
  assign rd_pop = move && !head.illegal && needs_load;

  always_comb begin
    rec = head;
    if (!head.illegal) begin
      // WB write only overrides the EX one when it really writes
      if (wb_reg.valid) begin
        rec.reg_wr = wb_reg;
      end
      if (needs_load) begin
        rec.mem.data = rd_data;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_seen_q <= 1'b0;
      wb_reg_q  <= '0;
    end else if (move && !head.illegal) begin
      wb_seen_q <= 1'b0;
      wb_reg_q  <= '0;
    end else if (!wb_seen_q && wb_event.wb_valid) begin
      // with an illegal head this wb belongs to the record behind it
      wb_seen_q <= 1'b1;
      wb_reg_q  <= wb_reg;
    end
  end

endmodule

//--- hdl/trace_ex_collect.sv
////////////////////
// adds EX register write and granted access to the ex queue head
// if the wb queue is full after ex_done, EX activity of the next
// instruction is not captured until the head moves on
////////////////////
module trace_ex_collect
  import trace_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  trace_rec_t head,
  input  logic       head_empty,
  input  logic       ex_done,
  input  ex_event_t  ex_event,
  input  logic       out_full,
  output logic       pop,
  output logic       push,
  output trace_rec_t rec
);

  // state gathered while the instruction sits in EX
  reg_wr_t  reg_q;
  mem_acc_t mem_q;
  // ex_done seen but the wb queue was full
  logic     done_q;

  reg_wr_t  cur_reg;
  mem_acc_t cur_mem;
  logic     move;

  // gathered state plus whatever EX shows this cycle
  always_comb begin
    cur_reg = reg_q;
    if (ex_event.reg_we) begin
      cur_reg.valid = 1'b1;
      cur_reg.addr  = ex_event.reg_addr;
      cur_reg.data  = ex_event.reg_wdata;
    end
    cur_mem = mem_q;
    if (ex_event.data_req && ex_event.data_gnt) begin
      cur_mem.valid = 1'b1;
      cur_mem.we    = ex_event.data_we;
      cur_mem.addr  = ex_event.data_addr;
      // load data is filled in at WB
      cur_mem.data  = ex_event.data_we ? ex_event.data_wdata : '0;
    end
  end

  // illegal records never see EX, they leave as soon as there is room
  assign move = !head_empty && !out_full && (head.illegal || ex_done || done_q);
  assign pop  = move;
  assign push = move;

  always_comb begin
    rec = head;
    if (!head.illegal) begin
      rec.reg_wr = done_q ? reg_q : cur_reg;
      rec.mem    = done_q ? mem_q : cur_mem;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reg_q  <= '0;
      mem_q  <= '0;
      done_q <= 1'b0;
    end else if (move && !head.illegal) begin
      reg_q  <= '0;
      mem_q  <= '0;
      done_q <= 1'b0;
    end else if (!done_q) begin
      // an illegal head does not clear, activity belongs to the next one
      reg_q  <= cur_reg;
      mem_q  <= cur_mem;
      done_q <= ex_done;
    end
  end

  // every instruction leaving EX was queued at decode
  a_ex_done_head: assert property (@(posedge clk) disable iff (!rst_n)
    ex_done |-> !head_empty)
    else $error("ex_done with no record in the ex queue");

endmodule

//--- hdl/trace_id_capture.sv
////////////////////
// opens one record per decode event and pushes it to the ex queue
// a record that meets a full queue is dropped, lost stays set until reset
////////////////////
module trace_id_capture
  import trace_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       if_valid,
  input  logic       pc_set,
  input  logic       is_interrupt,
  input  irq_no_t    irq_no,
  input  half_t      instr_compressed,
  input  logic       id_fire,
  input  id_event_t  id_event,
  input  cycle_t     cycle,
  input  logic       q_full,
  output logic       push,
  output trace_rec_t rec,
  output logic       lost
);

  // interrupt pending in IF, then handed to ID with the fetch
  logic    irq_if;
  irq_no_t irq_no_if;
  logic    irq_id;
  irq_no_t irq_no_id;
  // compressed half that travels with the instruction into ID
  half_t   half_id;

  ////////////////////
  // IF to ID handoff
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_if <= 1'b0;
      irq_id <= 1'b0;
    end else begin
      // pc_set opens the interrupt window, next fetch closes it
      if (pc_set) begin
        irq_if <= is_interrupt;
      end else if (if_valid) begin
        irq_if <= 1'b0;
      end
      if (if_valid) begin
        irq_id <= irq_if;
      end
    end
  end

  // payload side, follows the same enables
  always_ff @(posedge clk) begin
    if (pc_set) begin
      irq_no_if <= irq_no;
    end
    if (if_valid) begin
      half_id   <= instr_compressed;
      irq_no_id <= irq_no_if;
    end
  end

  ////////////////////
  // record build
  ////////////////////
  always_comb begin
    rec         = '0;
    rec.pc      = id_event.pc;
    rec.cycle   = cycle;
    rec.illegal = id_event.is_illegal;
    // compressed instructions show the latched half twice
    if (id_event.is_compressed) begin
      rec.instr = {half_id, half_id};
    end else begin
      rec.instr = id_event.instr;
    end
    if (irq_id) begin
      rec.irq    = 1'b1;
      rec.irq_no = irq_no_id;
    end
  end

  assign push = id_fire && !q_full;

  // sticky drop flag
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lost <= 1'b0;
    end else if (id_fire && q_full) begin
      lost <= 1'b1;
    end
  end

endmodule

//--- hdl/trace_cycle_counter.sv
////////////////////
// free-running cycle stamp, wraps silently after 2^32 cycles
////////////////////
module trace_cycle_counter
  import trace_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  output cycle_t cycle
);

  cycle_t cnt;

  // reads 0 at the first edge after reset release
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  assign cycle = cnt;

endmodule

//--- hdl/trace_fifo.sv
////////////////////
// show-ahead FIFO, dout is the head whenever empty is low
// push when full or pop when empty is a caller error
////////////////////
module trace_fifo #(
  parameter int  DEPTH = 4,
  parameter type T     = logic
) (
  input  logic clk,
  input  logic rst_n,
  input  logic push,
  input  T     din,
  input  logic pop,
  output T     dout,
  output logic full,
  output logic empty
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  T              mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;

  // pointer step with wrap at DEPTH, depth need not be a power of two
  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
    logic [PW-1:0] n;
    n = p + 1'b1;
    if (p == PW'(DEPTH - 1)) begin
      n = '0;
    end
    return n;
  endfunction

  // storage, no reset on payload
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // occupancy only moves when exactly one side fires
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  assign dout  = mem[rd_ptr];
  assign full  = (count == CW'(DEPTH));
  assign empty = (count == '0);

  // producers upstream must look at full before pushing
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    !(push && full))
    else $error("push into full trace fifo");

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    !(pop && empty))
    else $error("pop from empty trace fifo");

endmodule

//--- hdl/trace_pkg.sv
////////////////////
// widths, typedefs and record layout shared by the trace unit
// one register write and one memory access per record at most
////////////////////
package trace_pkg;

  // default queue depth and credits handed to the sink at reset
  parameter int TRACE_DEPTH   = 4;
  parameter int TRACE_CREDITS = 4;

  ////////////////////
  // plain vector types
  ////////////////////
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [15:0] half_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [4:0]  irq_no_t;
  typedef logic [31:0] cycle_t;
  // 4 bits hold CREDITS up to 15
  typedef logic [3:0]  credit_t;

  ////////////////////
  // record parts
  ////////////////////
  typedef struct packed {
    logic      valid;
    reg_addr_t addr;
    word_t     data;
  } reg_wr_t;

  // data holds store data when we is set and load data otherwise
  typedef struct packed {
    logic  valid;
    logic  we;
    addr_t addr;
    word_t data;
  } mem_acc_t;

  typedef struct packed {
    addr_t    pc;
    word_t    instr;
    cycle_t   cycle;
    logic     irq;
    irq_no_t  irq_no;
    logic     illegal;
    reg_wr_t  reg_wr;
    mem_acc_t mem;
  } trace_rec_t;

  ////////////////////
  // core side events
  ////////////////////
  typedef struct packed {
    addr_t pc;
    word_t instr;
    logic  is_compressed;
    logic  is_illegal;
  } id_event_t;

  typedef struct packed {
    logic      reg_we;
    reg_addr_t reg_addr;
    word_t     reg_wdata;
    logic      data_req;
    logic      data_gnt;
    logic      data_we;
    addr_t     data_addr;
    word_t     data_wdata;
  } ex_event_t;

  typedef struct packed {
    logic      wb_valid;
    logic      reg_we;
    reg_addr_t reg_addr;
    word_t     reg_wdata;
  } wb_event_t;

endpackage
